// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_rv_front
FILELIST   := all.f
OBJ_DIR    := obj_dir
BUILD_FLAGS := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS  := --lint-only --timing -Wall --top-module $(TOP)
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+include
verilog/rv_front_pkg.sv
verilog/instr_mem.sv
verilog/apb_arbiter.sv
verilog/fetch_unit.sv
verilog/instruction_register.sv
verilog/rv_front_top.sv
bench/tb_rv_front.sv

// File: bench/tb_rv_front.sv
`timescale 1ns/100ps
`include "fetch_params.svh"

module tb_rv_front;
  import rv_front_pkg::*;

  localparam int WS            = `MEM_WAIT_STATES;
  localparam int WORDS         = `MEM_WORDS;
  localparam int N_CLASSES     = 57;
  localparam int N_DECODE      = WORDS + 8;  // Enough fetches to wrap
  localparam int N_CONT        = 48;
  localparam int N_ILL_FETCH   = WORDS;
  localparam int N_TAIL        = 4;
  localparam int HOST_WAIT_MAX = 20;
  localparam int FETCH_GAP_MAX = 3 * (WS + 3);
  localparam int RUN_DRAIN     = 20;
  // Host ops during fetching may each sit behind one fetch
  localparam int N_XFERS = 2 * WORDS + N_DECODE + 2 * N_CONT + 2 * WORDS + N_ILL_FETCH + N_TAIL;
  localparam int CYCLE_LIMIT = N_XFERS * (2 * WS + 3) + 200;

  // Fixed bits of each class in code order, SYSTEM privileged ops last
  localparam word_t MATCH [N_CLASSES] = '{
    32'h0000_0033, 32'h4000_0033, 32'h0000_1033, 32'h0000_2033, 32'h0000_3033,
    32'h0000_4033, 32'h0000_5033, 32'h4000_5033, 32'h0000_6033, 32'h0000_7033,
    32'h0200_0033, 32'h0200_1033, 32'h0200_2033, 32'h0200_3033, 32'h0200_4033,
    32'h0200_5033, 32'h0200_6033, 32'h0200_7033,
    32'h0000_0013, 32'h0000_2013, 32'h0000_3013, 32'h0000_4013, 32'h0000_6013,
    32'h0000_7013, 32'h0000_1013, 32'h0000_5013, 32'h4000_5013,
    32'h0000_0003, 32'h0000_1003, 32'h0000_2003, 32'h0000_4003, 32'h0000_5003,
    32'h0000_0023, 32'h0000_1023, 32'h0000_2023,
    32'h0000_0063, 32'h0000_1063, 32'h0000_4063, 32'h0000_5063, 32'h0000_6063,
    32'h0000_7063,
    32'h0000_006F, 32'h0000_0067, 32'h0000_0037, 32'h0000_0017,
    32'h0000_1073, 32'h0000_2073, 32'h0000_3073, 32'h0000_5073, 32'h0000_6073,
    32'h0000_7073,
    32'h0000_0073, 32'h0010_0073, 32'h1020_0073, 32'h3020_0073, 32'h1050_0073,
    32'h1200_0073
  };
  localparam int SYS_CODE [6] = '{53, 54, 56, 57, 58, 59};

  logic        clk;
  logic        arst_n;
  logic        run;
  addr_t       host_paddr;
  logic        host_psel;
  logic        host_penable;
  logic        host_pwrite;
  word_t       host_pwdata;
  word_t       host_prdata;
  logic        host_pready;
  word_t       ir;
  instr_code_e instr_code;
  addr_t       instr_pc;
  logic        fetch_over;

  word_t model_mem [WORDS];  // Mirrors every completed host write
  addr_t expect_pc;
  int    fetch_count;
  int    cycle_cnt;
  logic  run_seen;
  logic  over_prev;
  int    word_errs;
  int    code_errs;
  int    pc_errs;
  int    other_errs;

  rv_front_top dut0 (
    .clk, .arst_n, .run,
    .host_paddr, .host_psel, .host_penable, .host_pwrite, .host_pwdata,
    .host_prdata, .host_pready,
    .ir, .instr_code, .instr_pc, .fetch_over
  );

  always #50 clk = ~clk;

  // Which bits of a class are fixed, from the ISA encoding formats
  function automatic word_t class_mask(input word_t m);
    if (m[6:0] == 7'h33) return 32'hFE00_707F;
    if (m[6:0] == 7'h13 && (m[14:12] == 3'd1 || m[14:12] == 3'd5)) return 32'hFE00_707F;
    if (m[6:0] == 7'h6F || m[6:0] == 7'h37 || m[6:0] == 7'h17) return 32'h0000_007F;
    if (m[6:0] == 7'h73 && m[14:12] == 3'd0) return 32'hFFFF_FFFF;
    return 32'h0000_707F;
  endfunction

  function automatic instr_code_e class_code(input int i);
    if (i < 51) return instr_code_e'(i);
    return instr_code_e'(SYS_CODE[i - 51]);
  endfunction

  // First class whose fixed bits match, anything else is illegal
  function automatic instr_code_e model_decode(input word_t w);
    for (int i = 0; i < N_CLASSES; i++) begin
      if ((w & class_mask(MATCH[i])) == MATCH[i]) return class_code(i);
    end
    return ILLEGAL;
  endfunction

  function automatic word_t valid_word(input int i);
    return MATCH[i] | ($urandom & ~class_mask(MATCH[i]));
  endfunction

  // Known opcode with random function fields
  function automatic word_t opcode_word();
    return ($urandom & 32'hFFFF_FF80) | (MATCH[$urandom % N_CLASSES] & 32'h0000_007F);
  endfunction

  function automatic word_t mixed_word();
    int r;
    r = $urandom % 4;
    if (r < 2) return valid_word($urandom % N_CLASSES);
    if (r == 2) return opcode_word();
    return $urandom;
  endfunction

  function automatic addr_t rand_addr();
    return addr_t'(($urandom % WORDS) * 4);
  endfunction

  function automatic int word_index(input addr_t a);
    return int'(a >> 2);
  endfunction

  function automatic addr_t next_pc(input addr_t pc);
    return (int'(pc) == (WORDS - 1) * 4) ? '0 : pc + addr_t'(4);
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      word_errs++;
      $display("FAIL %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_code(input string name, input instr_code_e exp, input instr_code_e act);
    if (act !== exp) begin
      code_errs++;
      $display("FAIL %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_pc(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      pc_errs++;
      $display("FAIL %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  // One APB transfer on the host port, entered 10 ns after a rising edge
  task automatic host_xfer(input logic wr, input addr_t addr, input word_t wdata,
                           output word_t rdata);
    int waits;
    host_paddr   = addr;
    host_pwrite  = wr;
    host_pwdata  = wdata;
    host_psel    = 1'b1;
    host_penable = 1'b0;
    @(posedge clk);
    #10 host_penable = 1'b1;
    waits = 0;
    @(negedge clk);
    while (!host_pready && waits < HOST_WAIT_MAX) begin
      waits++;
      @(negedge clk);
    end
    if (!host_pready) begin
      other_errs++;
      $display("Host transfer to address %h never got pready", addr);
    end else if (wr) begin
      model_mem[word_index(addr)] = wdata;
    end
    rdata = host_prdata;
    @(posedge clk);
    #10;
    host_psel    = 1'b0;
    host_penable = 1'b0;
  endtask

  task automatic host_write(input addr_t addr, input word_t data);
    word_t unused;
    host_xfer(1'b1, addr, data, unused);
  endtask

  task automatic host_read_check(input addr_t addr);
    word_t data;
    host_xfer(1'b0, addr, '0, data);
    check_word("host_prdata", model_mem[word_index(addr)], data);
  endtask

  task automatic wait_fetches(input int n);
    int target;
    int cycles;
    target = fetch_count + n;
    cycles = 0;
    while (fetch_count < target && cycles < n * FETCH_GAP_MAX) begin
      @(posedge clk);
      cycles++;
    end
    if (fetch_count < target) begin
      other_errs++;
      $display("Missing fetch_over, saw %0d of %0d pulses in %0d cycles",
               fetch_count - target + n, n, cycles);
    end
    #10;
  endtask

  // Every result checked against the model at its expected pc
  always @(negedge clk) begin
    if (arst_n && fetch_over) begin
      if (!run_seen) begin
        other_errs++;
        $display("fetch_over pulsed before run was raised at %0t", $time);
      end
      if (over_prev) begin
        other_errs++;
        $display("fetch_over stayed high for more than one cycle at %0t", $time);
      end
      check_pc("instr_pc", expect_pc, instr_pc);
      check_word("ir", model_mem[word_index(expect_pc)], ir);
      check_code("instr_code", model_decode(model_mem[word_index(expect_pc)]), instr_code);
      expect_pc = next_pc(expect_pc);
      fetch_count++;
    end
    over_prev = fetch_over;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    int base;
    int total;
    clk          = 1'b0;
    arst_n       = 1'b0;
    run          = 1'b0;
    host_paddr   = '0;
    host_psel    = 1'b0;
    host_penable = 1'b0;
    host_pwrite  = 1'b0;
    host_pwdata  = '0;
    expect_pc    = '0;
    fetch_count  = 0;
    cycle_cnt    = 0;
    run_seen     = 1'b0;
    over_prev    = 1'b0;
    word_errs    = 0;
    code_errs    = 0;
    pc_errs      = 0;
    other_errs   = 0;
    void'($urandom(72));
    repeat (8) @(posedge clk);
    #10 arst_n = 1'b1;

    // Program with every class once, random words after
    for (int a = 0; a < WORDS; a++) begin
      host_write(addr_t'(a * 4), (a < N_CLASSES) ? valid_word(a) : $urandom);
    end
    for (int a = 0; a < WORDS; a++) begin
      host_read_check(addr_t'(a * 4));
    end
    repeat (5) @(posedge clk);
    #10;

    run      = 1'b1;
    run_seen = 1'b1;
    wait_fetches(N_DECODE);

    // Host traffic racing the fetch unit
    for (int i = 0; i < N_CONT; i++) begin
      if ($urandom % 2) host_write(rand_addr(), mixed_word());
      else host_read_check(rand_addr());
    end
    wait_fetches(N_TAIL);

    // Mostly illegal words, loaded while fetching
    for (int a = 0; a < WORDS; a++) begin
      host_write(addr_t'(a * 4), (a % 2) ? opcode_word() : $urandom);
    end
    wait_fetches(N_ILL_FETCH);

    run  = 1'b0;
    base = fetch_count;
    repeat (RUN_DRAIN) @(posedge clk);
    if (fetch_count - base > 1) begin
      other_errs++;
      $display("%0d fetch_over pulses after run dropped, at most one allowed",
               fetch_count - base);
    end

    total = word_errs + code_errs + pc_errs + other_errs;
    $display("Errors: %0d (word %0d, code %0d, pc %0d, other %0d)",
             total, word_errs, code_errs, pc_errs, other_errs);
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: include/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Datapath width
`define XLEN 32

// Instruction memory depth in words
`define MEM_WORDS 64

// Byte address width, covers MEM_WORDS * 4 bytes
`define ADDR_W 8

// Extra access cycles before the memory raises pready
`define MEM_WAIT_STATES 1

`endif

// File: verilog/apb_arbiter.sv
`timescale 1ns/100ps

module apb_arbiter (
  input  logic                clk,
  input  logic                arst_n,
  // Host slot
  input  rv_front_pkg::addr_t host_paddr,
  input  logic                host_psel,
  input  logic                host_penable,
  input  logic                host_pwrite,
  input  rv_front_pkg::word_t host_pwdata,
  output rv_front_pkg::word_t host_prdata,
  output logic                host_pready,
  // Fetch slot, reads only
  input  rv_front_pkg::addr_t fetch_paddr,
  input  logic                fetch_psel,
  input  logic                fetch_penable,
  output rv_front_pkg::word_t fetch_prdata,
  output logic                fetch_pready,
  // Memory side
  output rv_front_pkg::addr_t mem_paddr,
  output logic                mem_psel,
  output logic                mem_penable,
  output logic                mem_pwrite,
  output rv_front_pkg::word_t mem_pwdata,
  input  rv_front_pkg::word_t mem_prdata,
  input  logic                mem_pready
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_SETUP,
    ARB_ACCESS
  } arb_state_e;

  arb_state_e state;
  logic       gnt_fetch;    // Current grant, kept as last winner while idle
  logic       sel_penable;
  logic       done;

  // Round robin on a tie, otherwise whoever asks
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= ARB_IDLE;
      gnt_fetch <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (host_psel & fetch_psel) begin
            gnt_fetch <= ~gnt_fetch;
            state     <= ARB_SETUP;
          end else if (host_psel | fetch_psel) begin
            gnt_fetch <= fetch_psel;
            state     <= ARB_SETUP;
          end
        end
        ARB_SETUP:  state <= ARB_ACCESS;
        ARB_ACCESS: if (done) state <= ARB_IDLE;
        default:    state <= ARB_IDLE;
      endcase
    end
  end

  assign sel_penable = gnt_fetch ? fetch_penable : host_penable;
  assign done        = (state == ARB_ACCESS) & mem_pready;

  // Fresh setup cycle to memory for the granted slot
  assign mem_psel    = (state != ARB_IDLE);
  assign mem_penable = (state == ARB_ACCESS) & sel_penable;
  assign mem_paddr   = gnt_fetch ? fetch_paddr : host_paddr;
  assign mem_pwrite  = ~gnt_fetch & host_pwrite;
  assign mem_pwdata  = gnt_fetch ? '0 : host_pwdata;

  // Loser sees pready low until its own turn
  assign host_pready  = done & ~gnt_fetch;
  assign fetch_pready = done & gnt_fetch;
  assign host_prdata  = mem_prdata;
  assign fetch_prdata = mem_prdata;

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_unit (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 run,
  output rv_front_pkg::addr_t  paddr,
  output logic                 psel,
  output logic                 penable,
  input  rv_front_pkg::word_t  prdata,
  input  logic                 pready,
  output rv_front_pkg::word_t  word,
  output logic                 valid,
  output rv_front_pkg::phase_t phase,
  output rv_front_pkg::addr_t  word_pc
);
  import rv_front_pkg::*;

  typedef enum logic [1:0] {
    F_IDLE,
    F_SETUP,
    F_ACCESS,
    F_EXEC
  } fetch_state_e;

  localparam addr_t LAST_PC = addr_t'((`MEM_WORDS - 1) * 4);

  fetch_state_e state;
  addr_t        pc;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= F_IDLE;
      pc    <= '0;
    end else begin
      case (state)
        F_IDLE:   if (run) state <= F_SETUP;
        F_SETUP:  state <= F_ACCESS;
        F_ACCESS: if (pready) state <= F_EXEC;  // Read finishes even if run dropped
        F_EXEC: begin
          pc    <= (pc == LAST_PC) ? '0 : pc + addr_t'(4);
          state <= run ? F_SETUP : F_IDLE;
        end
        default:  state <= F_IDLE;
      endcase
    end
  end

  // APB requester side
  assign paddr   = pc;
  assign psel    = (state == F_SETUP) | (state == F_ACCESS);
  assign penable = (state == F_ACCESS);

  // Word handed on in the pready cycle
  assign valid   = (state == F_ACCESS) & pready;
  assign word    = prdata;
  assign word_pc = pc;
  assign phase   = psel ? FETCH : EXECUTE;  // Idle counts as EXECUTE

endmodule

// File: verilog/instr_mem.sv
`timescale 1ns/100ps
`include "fetch_params.svh"

module instr_mem (
  input  logic                clk,
  input  logic                arst_n,
  input  rv_front_pkg::addr_t paddr,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  rv_front_pkg::word_t pwdata,
  output rv_front_pkg::word_t prdata,
  output logic                pready
);
  import rv_front_pkg::*;

  localparam int IDX_W  = $clog2(`MEM_WORDS);
  localparam int WAIT_W = (`MEM_WAIT_STATES > 0) ? $clog2(`MEM_WAIT_STATES + 1) : 1;

  word_t             mem [`MEM_WORDS];
  logic [IDX_W-1:0]  idx;
  logic [WAIT_W-1:0] wait_cnt;  // Access cycles spent so far
  logic              access;

  assign idx    = paddr[IDX_W+1:2];  // Byte address to word index
  assign access = psel & penable;
  assign pready = access & (wait_cnt == WAIT_W'(`MEM_WAIT_STATES));
  assign prdata = mem[idx];          // Sampled by the requester on pready

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wait_cnt <= '0;
    end else if (pready) begin
      wait_cnt <= '0;                // Ready for the next transfer
    end else if (access) begin
      wait_cnt <= wait_cnt + WAIT_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (pready & pwrite) begin
      mem[idx] <= pwdata;
    end
  end

endmodule

// File: verilog/instruction_register.sv
`timescale 1ns/100ps

module instruction_register (
  input  logic                       clk,
  input  logic                       arst_n,
  input  rv_front_pkg::word_t        word,
  input  rv_front_pkg::addr_t        word_pc,
  input  logic                       valid,
  input  rv_front_pkg::phase_t       phase,
  output rv_front_pkg::word_t        ir,
  output rv_front_pkg::instr_code_e  instr_code,
  output rv_front_pkg::addr_t        instr_pc,
  output logic                       fetch_over
);
  import rv_front_pkg::*;

  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  logic capture;

  // Unmatched function fields fall through to ILLEGAL
  function automatic instr_code_e decode(input word_t w);
    logic [2:0]  f3;
    logic [6:0]  f7;
    instr_code_e code;
    f3   = w[14:12];
    f7   = w[31:25];
    code = ILLEGAL;
    case (w[6:0])
      OP_REG: begin
        if (f7 == 7'b0000001) begin
          case (f3)  // M extension
            3'b000: code = MUL;
            3'b001: code = MULH;
            3'b010: code = MULHSU;
            3'b011: code = MULHU;
            3'b100: code = DIV;
            3'b101: code = DIVU;
            3'b110: code = REM;
            default: code = REMU;
          endcase
        end else if (f7 == 7'b0000000) begin
          case (f3)
            3'b000: code = ADD;
            3'b001: code = SLL;
            3'b010: code = SLT;
            3'b011: code = SLTU;
            3'b100: code = XOR;
            3'b101: code = SRL;
            3'b110: code = OR;
            default: code = AND;
          endcase
        end else if (f7 == 7'b0100000) begin
          if (f3 == 3'b000) code = SUB;
          else if (f3 == 3'b101) code = SRA;
        end
      end
      OP_IMM: begin
        case (f3)
          3'b000: code = ADDI;
          3'b010: code = SLTI;
          3'b011: code = SLTIU;
          3'b100: code = XORI;
          3'b110: code = ORI;
          3'b111: code = ANDI;
          3'b001: if (f7 == 7'b0000000) code = SLLI;
          default: begin
            if (f7 == 7'b0000000) code = SRLI;
            else if (f7 == 7'b0100000) code = SRAI;
          end
        endcase
      end
      OP_LOAD: begin
        if (f3 == 3'b000) code = LB;
        else if (f3 == 3'b001) code = LH;
        else if (f3 == 3'b010) code = LW;
        else if (f3 == 3'b100) code = LBU;
        else if (f3 == 3'b101) code = LHU;
      end
      OP_STORE: begin
        if (f3 == 3'b000) code = SB;
        else if (f3 == 3'b001) code = SH;
        else if (f3 == 3'b010) code = SW;
      end
      OP_BRANCH: begin
        if (f3 == 3'b000) code = BEQ;
        else if (f3 == 3'b001) code = BNE;
        else if (f3 == 3'b100) code = BLT;
        else if (f3 == 3'b101) code = BGE;
        else if (f3 == 3'b110) code = BLTU;
        else if (f3 == 3'b111) code = BGEU;
      end
      OP_JAL:   code = JAL;
      OP_JALR:  if (f3 == 3'b000) code = JALR;
      OP_LUI:   code = LUI;
      OP_AUIPC: code = AUIPC;
      OP_SYSTEM: begin
        case (f3)
          3'b001: code = CSRRW;
          3'b010: code = CSRRS;
          3'b011: code = CSRRC;
          3'b101: code = CSRRWI;
          3'b110: code = CSRRSI;
          3'b111: code = CSRRCI;
          3'b000: begin
            // Privileged ops need the whole word
            case (w)
              32'h0000_0073: code = ECALL;
              32'h0010_0073: code = EBREAK;
              32'h0020_0073: code = ILLEGAL;  // URET
              32'h1020_0073: code = SRET;
              32'h3020_0073: code = MRET;
              32'h1050_0073: code = WFI;
              32'h1200_0073: code = SFENCE_VMA;
              default:       code = ILLEGAL;
            endcase
          end
          default: code = ILLEGAL;
        endcase
      end
      default: code = ILLEGAL;
    endcase
    return code;
  endfunction

  assign capture = valid & (phase == FETCH);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch_over <= 1'b0;
    end else begin
      fetch_over <= capture;  // One pulse per captured word
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      ir         <= word;
      instr_code <= decode(word);
      instr_pc   <= word_pc;
    end
  end

endmodule

// File: verilog/rv_front_pkg.sv
`include "fetch_params.svh"

package rv_front_pkg;

  typedef logic [`XLEN-1:0]   word_t;  // One instruction word
  typedef logic [`ADDR_W-1:0] addr_t;  // Byte address

  // FETCH while a word is on its way, EXECUTE otherwise
  typedef enum logic {
    FETCH   = 1'b0,
    EXECUTE = 1'b1
  } phase_t;

  typedef enum logic [7:0] {
    // Register-register, base and M extension
    ADD = 8'd0, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    MUL = 8'd10, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
    // Register-immediate
    ADDI = 8'd18, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
    // Loads and stores
    LB = 8'd27, LH, LW, LBU, LHU,
    SB = 8'd32, SH, SW,
    // Branches
    BEQ = 8'd35, BNE, BLT, BGE, BLTU, BGEU,
    // Jumps and upper immediates
    JAL   = 8'd41,
    JALR  = 8'd42,
    LUI   = 8'd43,
    AUIPC = 8'd44,
    // CSR access
    CSRRW = 8'd45, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
    // System, 51 52 and 55 unused
    ECALL      = 8'd53,
    EBREAK     = 8'd54,
    SRET       = 8'd56,
    MRET       = 8'd57,
    WFI        = 8'd58,
    SFENCE_VMA = 8'd59,
    ILLEGAL    = 8'd255  // Also URET
  } instr_code_e;

endpackage

// File: verilog/rv_front_top.sv
`timescale 1ns/100ps

module rv_front_top (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      run,
  // Host APB port
  input  rv_front_pkg::addr_t       host_paddr,
  input  logic                      host_psel,
  input  logic                      host_penable,
  input  logic                      host_pwrite,
  input  rv_front_pkg::word_t       host_pwdata,
  output rv_front_pkg::word_t       host_prdata,
  output logic                      host_pready,
  // Decoded instruction
  output rv_front_pkg::word_t       ir,
  output rv_front_pkg::instr_code_e instr_code,
  output rv_front_pkg::addr_t       instr_pc,
  output logic                      fetch_over
);
  import rv_front_pkg::*;

  addr_t  fetch_paddr;
  logic   fetch_psel;
  logic   fetch_penable;
  word_t  fetch_prdata;
  logic   fetch_pready;

  addr_t  mem_paddr;
  logic   mem_psel;
  logic   mem_penable;
  logic   mem_pwrite;
  word_t  mem_pwdata;
  word_t  mem_prdata;
  logic   mem_pready;

  word_t  word;
  logic   valid;
  phase_t phase;
  addr_t  word_pc;

  fetch_unit u_fetch (
    .clk, .arst_n, .run,
    .paddr(fetch_paddr), .psel(fetch_psel), .penable(fetch_penable),
    .prdata(fetch_prdata), .pready(fetch_pready),
    .word, .valid, .phase, .word_pc
  );

  apb_arbiter u_arb (
    .clk, .arst_n,
    .host_paddr, .host_psel, .host_penable, .host_pwrite, .host_pwdata,
    .host_prdata, .host_pready,
    .fetch_paddr, .fetch_psel, .fetch_penable, .fetch_prdata, .fetch_pready,
    .mem_paddr, .mem_psel, .mem_penable, .mem_pwrite, .mem_pwdata,
    .mem_prdata, .mem_pready
  );

  instr_mem u_mem (
    .clk, .arst_n,
    .paddr(mem_paddr), .psel(mem_psel), .penable(mem_penable),
    .pwrite(mem_pwrite), .pwdata(mem_pwdata),
    .prdata(mem_prdata), .pready(mem_pready)
  );

  instruction_register u_ir (
    .clk, .arst_n, .word, .word_pc, .valid, .phase,
    .ir, .instr_code, .instr_pc, .fetch_over
  );

endmodule
